// ==== rtl/obs_consts.svh ====
`ifndef OBS_CONSTS_SVH
`define OBS_CONSTS_SVH

// data and address width
`define OBS_XLEN 32
`define OBS_REG_ADDR_W 5

// major opcodes
`define OBS_OPC_LOAD 7'h03
`define OBS_OPC_STORE 7'h23
`define OBS_OPC_BRANCH 7'h63
`define OBS_OPC_OP 7'h33

// funct7 of the M extension
`define OBS_FUNCT7_MULDIV 7'h01

// access size in funct3[1:0] of loads and stores
`define OBS_F3_SIZE_BYTE 2'b00
`define OBS_F3_SIZE_HALF 2'b01

`endif

// ==== rtl/isa_pkg.sv ====
`include "obs_consts.svh"

package isa_pkg;

	// register-register format
	typedef struct packed {
		logic [6:0] funct7;
		logic [`OBS_REG_ADDR_W-1:0] rs2;
		logic [`OBS_REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [`OBS_REG_ADDR_W-1:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	// immediate format, used by loads
	typedef struct packed {
		logic [11:0] imm;
		logic [`OBS_REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [`OBS_REG_ADDR_W-1:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	// store format, immediate split around rs fields
	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [`OBS_REG_ADDR_W-1:0] rs2;
		logic [`OBS_REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [`OBS_REG_ADDR_W-1:0] rs2;
		logic [`OBS_REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	// one instruction word, four views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
	} instr_u;

	typedef enum logic [1:0] {
		acc_byte = 2'd0,
		acc_half = 2'd1,
		acc_word = 2'd2
	} access_size_e;

	// encoded like the branch funct3
	typedef enum logic [2:0] {
		cmp_eq = 3'd0,
		cmp_ne = 3'd1,
		cmp_lt = 3'd4,
		cmp_ge = 3'd5,
		cmp_ltu = 3'd6,
		cmp_geu = 3'd7
	} cmp_op_e;

endpackage

// ==== rtl/obs_pkg.sv ====
`include "obs_consts.svh"

package obs_pkg;

	typedef logic [`OBS_XLEN-1:0] xword_t;

	// at most one flag set per instruction
	typedef struct packed {
		logic is_load;
		logic is_store;
		logic is_branch;
		logic is_div;
	} instr_class_t;

	typedef struct packed {
		instr_class_t cls;
		logic [`OBS_REG_ADDR_W-1:0] rs1_addr;
		logic [`OBS_REG_ADDR_W-1:0] rs2_addr;
		xword_t imm;
		isa_pkg::access_size_e size;
		isa_pkg::cmp_op_e cmp_op;
	} decoded_t;

	// what leaks from one retired instruction
	typedef struct packed {
		xword_t pc;
		instr_class_t cls;
		xword_t mem_addr;
		logic misaligned;
		logic branch_taken;
		xword_t divisor;
	} obs_record_t;

endpackage

// ==== rtl/instr_classifier.sv ====
`include "obs_consts.svh"

module instr_classifier (
	input isa_pkg::instr_u instr_i,
	output obs_pkg::decoded_t dec_o,
	output logic [`OBS_REG_ADDR_W-1:0] rs1_addr_o,
	output logic [`OBS_REG_ADDR_W-1:0] rs2_addr_o
);
	import isa_pkg::*;
	import obs_pkg::*;

	logic [6:0] opcode;
	instr_class_t cls;
	xword_t imm_i;
	xword_t imm_s;

	// opcode sits in the same place in every format
	assign opcode = instr_i.r.opcode;

	assign cls.is_load = (opcode == `OBS_OPC_LOAD);
	assign cls.is_store = (opcode == `OBS_OPC_STORE);
	assign cls.is_branch = (opcode == `OBS_OPC_BRANCH);
	// div, divu, rem, remu
	assign cls.is_div = (opcode == `OBS_OPC_OP) &&
		(instr_i.r.funct7 == `OBS_FUNCT7_MULDIV) && instr_i.r.funct3[2];

	assign imm_i = {{(`OBS_XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
	assign imm_s = {{(`OBS_XLEN-12){instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5,
		instr_i.s.imm_4_0};

	always_comb begin
		dec_o = '0;
		dec_o.cls = cls;
		dec_o.rs1_addr = instr_i.r.rs1;
		dec_o.rs2_addr = instr_i.r.rs2;

		if (cls.is_load) begin
			dec_o.imm = imm_i;
		end else if (cls.is_store) begin
			dec_o.imm = imm_s;
		end

		// sign bit of funct3 only matters for the loaded data
		case (instr_i.i.funct3[1:0])
			`OBS_F3_SIZE_BYTE: dec_o.size = acc_byte;
			`OBS_F3_SIZE_HALF: dec_o.size = acc_half;
			default: dec_o.size = acc_word;
		endcase

		case (instr_i.b.funct3)
			3'b001: dec_o.cmp_op = cmp_ne;
			3'b100: dec_o.cmp_op = cmp_lt;
			3'b101: dec_o.cmp_op = cmp_ge;
			3'b110: dec_o.cmp_op = cmp_ltu;
			3'b111: dec_o.cmp_op = cmp_geu;
			// beq and the unused encodings
			default: dec_o.cmp_op = cmp_eq;
		endcase
	end

	assign rs1_addr_o = dec_o.rs1_addr;
	assign rs2_addr_o = dec_o.rs2_addr;

	// opcode matches and the muldiv check must never overlap
	always_comb begin
		assert ($onehot0(cls))
		else $error("instr_classifier: more than one class flag for %h", instr_i);
	end

endmodule

// ==== rtl/mem_addr_observer.sv ====
module mem_addr_observer (
	input obs_pkg::decoded_t dec_i,
	input obs_pkg::xword_t rs1_data_i,
	output obs_pkg::xword_t mem_addr_o,
	output logic misaligned_o
);
	import isa_pkg::*;
	import obs_pkg::*;

	logic is_mem;
	xword_t addr;
	logic split;

	assign is_mem = dec_i.cls.is_load | dec_i.cls.is_store;

	// imm is already zero outside loads and stores
	assign addr = rs1_data_i + dec_i.imm;

	// access crosses a word boundary
	always_comb begin
		case (dec_i.size)
			acc_word: split = (addr[1:0] != 2'b00);
			acc_half: split = (addr[1:0] == 2'b11);
			default: split = 1'b0;
		endcase
	end

	assign mem_addr_o = is_mem ? addr : '0;
	assign misaligned_o = is_mem & split;

endmodule

// ==== rtl/branch_observer.sv ====
`include "obs_consts.svh"

module branch_observer (
	input obs_pkg::decoded_t dec_i,
	input obs_pkg::xword_t rs1_data_i,
	input obs_pkg::xword_t rs2_data_i,
	output logic taken_o
);
	import isa_pkg::*;
	import obs_pkg::*;

	xword_t diff;
	logic is_equal;
	logic is_ge;
	logic cmp_signed;
	logic cmp_result;

	// one subtractor serves all six compares
	assign diff = rs1_data_i - rs2_data_i;
	assign is_equal = (diff == '0);

	assign cmp_signed = (dec_i.cmp_op == cmp_lt) || (dec_i.cmp_op == cmp_ge);

	always_comb begin
		if (rs1_data_i[`OBS_XLEN-1] == rs2_data_i[`OBS_XLEN-1]) begin
			// same sign, no overflow in the difference
			is_ge = ~diff[`OBS_XLEN-1];
		end else begin
			// signs differ, the msb of rs1 decides
			is_ge = rs1_data_i[`OBS_XLEN-1] ^ cmp_signed;
		end
	end

	always_comb begin
		case (dec_i.cmp_op)
			cmp_eq: cmp_result = is_equal;
			cmp_ne: cmp_result = ~is_equal;
			cmp_ge, cmp_geu: cmp_result = is_ge;
			cmp_lt, cmp_ltu: cmp_result = ~is_ge;
			default: cmp_result = is_equal;
		endcase
	end

	assign taken_o = dec_i.cls.is_branch & cmp_result;

endmodule

// ==== rtl/leakage_observer.sv ====
`include "obs_consts.svh"

module leakage_observer (
	input logic clk_i,
	input logic reset_i,
	input logic retire_i,
	input obs_pkg::xword_t pc_i,
	input isa_pkg::instr_u instr_i,
	input obs_pkg::xword_t rs1_data_i,
	input obs_pkg::xword_t rs2_data_i,
	output logic [`OBS_REG_ADDR_W-1:0] rs1_addr_o,
	output logic [`OBS_REG_ADDR_W-1:0] rs2_addr_o,
	output logic obs_valid_o,
	output obs_pkg::obs_record_t obs_o
);
	import obs_pkg::*;

	decoded_t dec;
	xword_t mem_addr;
	logic misaligned;
	logic taken;
	obs_record_t rec;

	instr_classifier u_classifier (
		.instr_i(instr_i),
		.dec_o(dec),
		.rs1_addr_o(rs1_addr_o),
		.rs2_addr_o(rs2_addr_o)
	);

	mem_addr_observer u_mem_addr (
		.dec_i(dec),
		.rs1_data_i(rs1_data_i),
		.mem_addr_o(mem_addr),
		.misaligned_o(misaligned)
	);

	branch_observer u_branch (
		.dec_i(dec),
		.rs1_data_i(rs1_data_i),
		.rs2_data_i(rs2_data_i),
		.taken_o(taken)
	);

	// record of the instruction retiring this cycle
	always_comb begin
		rec.pc = pc_i;
		rec.cls = dec.cls;
		rec.mem_addr = mem_addr;
		rec.misaligned = misaligned;
		rec.branch_taken = taken;
		rec.divisor = dec.cls.is_div ? rs2_data_i : '0;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			obs_valid_o <= 1'b0;
			obs_o <= '0;
		end else begin
			obs_valid_o <= retire_i;
			// hold the last record between retires
			if (retire_i) begin
				obs_o <= rec;
			end
		end
	end

	// one record per retire, exactly one cycle later
	assert property (@(posedge clk_i) disable iff (reset_i)
		retire_i |=> obs_valid_o);
	assert property (@(posedge clk_i) disable iff (reset_i)
		obs_valid_o |-> $past(retire_i));

	// flags from the observers agree with the decoded class
	assert property (@(posedge clk_i) disable iff (reset_i)
		obs_valid_o && obs_o.misaligned |-> obs_o.cls.is_load || obs_o.cls.is_store);
	assert property (@(posedge clk_i) disable iff (reset_i)
		obs_valid_o && obs_o.branch_taken |-> obs_o.cls.is_branch);

endmodule

// ==== sim/tb_leakage_observer.sv ====
`include "obs_consts.svh"

module tb_leakage_observer;
	timeunit 1ns;
	timeprecision 1ps;
	import isa_pkg::*;
	import obs_pkg::*;

	localparam int WAIT_LIMIT = 8;

	logic clk_i;
	logic reset_i;
	logic retire_i;
	xword_t pc_i;
	instr_u instr_i;
	xword_t rs1_data_i;
	xword_t rs2_data_i;
	logic [`OBS_REG_ADDR_W-1:0] rs1_addr_o;
	logic [`OBS_REG_ADDR_W-1:0] rs2_addr_o;
	logic obs_valid_o;
	obs_record_t obs_o;

	xword_t regfile [32];
	integer seed;
	int errors;
	int checks;
	int tests;
	int errors_at_start;

	leakage_observer dut_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.retire_i(retire_i),
		.pc_i(pc_i),
		.instr_i(instr_i),
		.rs1_data_i(rs1_data_i),
		.rs2_data_i(rs2_data_i),
		.rs1_addr_o(rs1_addr_o),
		.rs2_addr_o(rs2_addr_o),
		.obs_valid_o(obs_valid_o),
		.obs_o(obs_o)
	);

	always #50 clk_i = ~clk_i;

	// register file answers in the same cycle
	assign rs1_data_i = regfile[rs1_addr_o];
	assign rs2_data_i = regfile[rs2_addr_o];

	function automatic logic [31:0] enc_load(logic [2:0] f3, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, 5'd1, `OBS_OPC_LOAD};
	endfunction

	function automatic logic [31:0] enc_store(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
			logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `OBS_OPC_STORE};
	endfunction

	// fixed forward offset of 16 bytes
	function automatic logic [31:0] enc_branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
		return {7'b0000000, rs2, rs1, f3, 5'b10000, `OBS_OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_op(logic [6:0] f7, logic [2:0] f3, logic [4:0] rs1,
			logic [4:0] rs2);
		return {f7, rs2, rs1, f3, 5'd1, `OBS_OPC_OP};
	endfunction

	// expected record, straight from the raw instruction bits
	function automatic obs_record_t model_record(xword_t pc, logic [31:0] w, xword_t a,
			xword_t b);
		obs_record_t r;
		xword_t imm;
		r = '0;
		r.pc = pc;
		r.cls.is_load = (w[6:0] == `OBS_OPC_LOAD);
		r.cls.is_store = (w[6:0] == `OBS_OPC_STORE);
		r.cls.is_branch = (w[6:0] == `OBS_OPC_BRANCH);
		r.cls.is_div = (w[6:0] == `OBS_OPC_OP) && (w[31:25] == `OBS_FUNCT7_MULDIV) &&
			(w[14:12] >= 3'd4);
		imm = r.cls.is_load ? {{20{w[31]}}, w[31:20]} : {{20{w[31]}}, w[31:25], w[11:7]};
		if (r.cls.is_load || r.cls.is_store) begin
			r.mem_addr = a + imm;
			case (w[13:12])
				2'b00: r.misaligned = 1'b0;
				2'b01: r.misaligned = (r.mem_addr[1:0] == 2'd3);
				default: r.misaligned = (r.mem_addr[1:0] != 2'd0);
			endcase
		end
		if (r.cls.is_branch) begin
			case (w[14:12])
				3'd0: r.branch_taken = (a == b);
				3'd1: r.branch_taken = (a != b);
				3'd4: r.branch_taken = ($signed(a) < $signed(b));
				3'd5: r.branch_taken = ($signed(a) >= $signed(b));
				3'd6: r.branch_taken = (a < b);
				default: r.branch_taken = (a >= b);
			endcase
		end
		if (r.cls.is_div) begin
			r.divisor = b;
		end
		return r;
	endfunction

	task automatic check_word(input string name, input xword_t got, input xword_t exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input bit got, input bit exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_class(input string name, input instr_class_t got,
			input instr_class_t exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input logic [`OBS_REG_ADDR_W-1:0] got,
			input logic [`OBS_REG_ADDR_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_record(input obs_record_t exp);
		check_word("obs_o.pc", obs_o.pc, exp.pc);
		check_class("obs_o.cls", obs_o.cls, exp.cls);
		check_word("obs_o.mem_addr", obs_o.mem_addr, exp.mem_addr);
		check_flag("obs_o.misaligned", obs_o.misaligned, exp.misaligned);
		check_flag("obs_o.branch_taken", obs_o.branch_taken, exp.branch_taken);
		check_word("obs_o.divisor", obs_o.divisor, exp.divisor);
	endtask

	// to 5 ns after the next rising edge
	task automatic step();
		@(posedge clk_i);
		#5;
	endtask

	task automatic issue(input xword_t pc, input logic [31:0] w);
		pc_i = pc;
		instr_i = w;
		retire_i = 1'b1;
		#1;
		check_addr("rs1_addr_o", rs1_addr_o, w[19:15]);
		check_addr("rs2_addr_o", rs2_addr_o, w[24:20]);
	endtask

	task automatic await_record();
		int cycles;
		step();
		retire_i = 1'b0;
		cycles = 1;
		while (!obs_valid_o && cycles < WAIT_LIMIT) begin
			step();
			cycles++;
		end
		if (!obs_valid_o) begin
			$display("timeout: no record within %0d cycles of the retire", cycles);
			errors++;
		end else if (cycles != 1) begin
			$display("record came %0d cycles after the retire instead of 1", cycles);
			errors++;
		end
	endtask

	task automatic run_single(input xword_t pc, input logic [31:0] w);
		obs_record_t exp;
		exp = model_record(pc, w, regfile[w[19:15]], regfile[w[24:20]]);
		issue(pc, w);
		await_record();
		compare_record(exp);
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == errors_at_start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errors_at_start);
		end
	endtask

	task automatic test_reset_and_valid();
		obs_record_t exp;
		logic [31:0] w;
		errors_at_start = errors;
		// a retire under reset leaves no record
		pc_i = 32'h0000_0080;
		instr_i = enc_load(3'd2, 5'd1, 12'h004);
		retire_i = 1'b1;
		repeat (2) begin
			step();
			check_flag("obs_valid_o", obs_valid_o, 1'b0);
			compare_record('0);
		end
		reset_i = 1'b0;
		w = enc_op(7'h00, 3'd0, 5'd1, 5'd2);
		exp = model_record(32'h0000_0100, w, regfile[1], regfile[2]);
		issue(32'h0000_0100, w);
		await_record();
		compare_record(exp);
		// new inputs without a retire
		pc_i = 32'h0000_0200;
		instr_i = enc_load(3'd2, 5'd3, 12'h010);
		step();
		// pulse is over, record stays
		check_flag("obs_valid_o", obs_valid_o, 1'b0);
		compare_record(exp);
		finish_test("reset and valid timing");
	endtask

	task automatic test_loads();
		logic [11:0] imms [4];
		int f3;
		int k;
		errors_at_start = errors;
		imms = '{12'h024, 12'hff0, 12'h7ff, 12'h800};
		for (f3 = 0; f3 < 6; f3++) begin
			for (k = 0; k < 4; k++) begin
				if (f3 != 3) begin
					run_single(32'h0000_1000 + 4 * f3, enc_load(3'(f3), 5'(f3 + 1), imms[k]));
				end
			end
		end
		finish_test("loads");
	endtask

	task automatic test_stores();
		int f3;
		int off;
		errors_at_start = errors;
		regfile[8] = $random(seed) & 32'hffff_fffc;
		for (f3 = 0; f3 < 3; f3++) begin
			for (off = 0; off < 4; off++) begin
				run_single(32'h0000_2000, enc_store(3'(f3), 5'd8, 5'd9, 12'h010 + 12'(off)));
				run_single(32'h0000_2004, enc_store(3'(f3), 5'd8, 5'd9, 12'hfe0 + 12'(off)));
			end
		end
		finish_test("stores");
	endtask

	task automatic test_branches();
		xword_t a [6];
		xword_t b [6];
		int p;
		int k;
		errors_at_start = errors;
		// random, equal, sign crossing both ways, unsigned extremes
		a = '{32'h0, 32'h1234_5678, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0};
		b = '{32'h0, 32'h1234_5678, 32'h7fff_ffff, 32'h8000_0000, 32'h0, 32'hffff_ffff};
		a[0] = $random(seed);
		b[0] = $random(seed);
		for (p = 0; p < 6; p++) begin
			regfile[12] = a[p];
			regfile[13] = b[p];
			// funct3 0, 1 and 4 to 7
			for (k = 0; k < 6; k++) begin
				run_single(32'h0000_3000, enc_branch(3'(k < 2 ? k : k + 2), 5'd12, 5'd13));
			end
		end
		finish_test("branches");
	endtask

	task automatic test_divides();
		int f3;
		errors_at_start = errors;
		for (f3 = 0; f3 < 8; f3++) begin
			run_single(32'h0000_4000, enc_op(`OBS_FUNCT7_MULDIV, 3'(f3), 5'd14, 5'd15));
		end
		run_single(32'h0000_4004, enc_op(7'h00, 3'd4, 5'd14, 5'd15));
		run_single(32'h0000_4008, enc_op(7'h20, 3'd5, 5'd14, 5'd15));
		finish_test("divides");
	endtask

	task automatic test_back_to_back();
		logic [31:0] words [6];
		obs_record_t exp;
		xword_t pc;
		int i;
		errors_at_start = errors;
		words[0] = enc_load(3'd2, 5'd3, 12'h001);
		words[1] = enc_store(3'd1, 5'd4, 5'd5, 12'h7fd);
		words[2] = enc_branch(3'd4, 5'd6, 5'd7);
		words[3] = enc_op(`OBS_FUNCT7_MULDIV, 3'd6, 5'd8, 5'd9);
		words[4] = enc_op(7'h00, 3'd0, 5'd10, 5'd11);
		words[5] = enc_branch(3'd0, 5'd12, 5'd12);
		pc = $random(seed) & 32'hffff_fffc;
		for (i = 0; i < 6; i++) begin
			exp = model_record(pc, words[i], regfile[words[i][19:15]], regfile[words[i][24:20]]);
			issue(pc, words[i]);
			step();
			if (!obs_valid_o) begin
				$display("record %0d missing in the cycle after its retire", i);
				errors++;
			end
			compare_record(exp);
			pc = pc + 4;
		end
		retire_i = 1'b0;
		step();
		check_flag("obs_valid_o", obs_valid_o, 1'b0);
		finish_test("back-to-back retires");
	endtask

	initial begin
		int r;
		seed = 32'h740;
		errors = 0;
		checks = 0;
		tests = 0;
		clk_i = 1'b0;
		reset_i = 1'b1;
		retire_i = 1'b0;
		pc_i = '0;
		instr_i = '0;
		for (r = 0; r < 32; r++) begin
			regfile[r] = $random(seed);
		end
		test_reset_and_valid();
		test_loads();
		test_stores();
		test_branches();
		test_divides();
		test_back_to_back();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== leakage_obs.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/obs_pkg.sv
rtl/instr_classifier.sv
rtl/mem_addr_observer.sv
rtl/branch_observer.sv
rtl/leakage_observer.sv
sim/tb_leakage_observer.sv

// ==== Makefile ====
VERILATOR := verilator
TOP := tb_leakage_observer
FILELIST := leakage_obs.f
BUILD_DIR := obj_dir
LOG := sim.log
VFLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
